// ==== hw/idiv_controller.sv ====
`timescale 1ns/1ps
`include "idiv_params.svh"

module idiv_controller (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   v_i,
    output logic                   ready_o,
    input  idiv_pkg::idiv_status_t status_i,
    input  logic [`IDIV_CNT_W-1:0] div_shift_i,
    output idiv_pkg::idiv_ctrl_t   ctrl_o,
    output logic                   v_o,
    input  logic                   yumi_i
);

    import idiv_pkg::*;

    localparam logic [`IDIV_CNT_W-1:0] FULL_CNT = `IDIV_CNT_W'(`IDIV_WIDTH);

    idiv_state_e state_q;
    idiv_state_e state_d;

    logic                   q_neg_q;
    logic                   r_neg_q;
    logic                   neg_ld;
    logic                   add_neg_last_q;
    logic [`IDIV_CNT_W-1:0] calc_cnt_q;
    logic [`IDIV_CNT_W-1:0] calc_cyc_q;
    logic                   full_run;
    logic                   calc_done;

    // signed and zero-divisor requests skip the early shift
    assign full_run  = status_i.signed_div_r | status_i.zero_divisor;
    assign calc_done = (calc_cnt_q == calc_cyc_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q        <= wait_s;
            calc_cnt_q     <= '0;
            calc_cyc_q     <= '0;
            q_neg_q        <= 1'b0;
            r_neg_q        <= 1'b0;
            add_neg_last_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            add_neg_last_q <= status_i.adder_neg;
            if (neg_ld) begin
                // quotient negative when operand signs differ
                q_neg_q <= (status_i.opa_neg ^ status_i.opc_neg) & status_i.signed_div_r;
                // remainder follows the dividend
                r_neg_q <= status_i.opc_neg & status_i.signed_div_r;
            end
            // count is latched before C starts shifting
            if (state_q == shift_s) begin
                calc_cyc_q <= full_run ? FULL_CNT : div_shift_i;
            end
            if (state_q == calc_s) begin
                calc_cnt_q <= calc_done ? '0 : calc_cnt_q + 1'b1;
            end
        end
    end

    // ====================
    // next state and controls
    // ====================

    always_comb begin
        ctrl_o              = '0;
        ctrl_o.opa_sel      = 2'b01;
        ctrl_o.opa_clr_n    = 1'b1;
        ctrl_o.opb_sel      = 3'b010;
        ctrl_o.opb_clr_n    = 1'b1;
        ctrl_o.opc_sel      = 3'b001;
        // subtract after a non-negative step, add after a negative one
        ctrl_o.opa_inv      = ~add_neg_last_q;
        ctrl_o.adder_cin    = ~add_neg_last_q;
        neg_ld              = 1'b0;
        state_d             = state_q;

        unique case (state_q)
            wait_s: begin
                if (v_i) begin
                    ctrl_o.opa_sel      = 2'b10;
                    ctrl_o.opa_ld       = 1'b1;
                    ctrl_o.opc_sel      = 3'b100;
                    ctrl_o.opc_ld       = 1'b1;
                    ctrl_o.latch_signed = 1'b1;
                    state_d             = neg0_s;
                end
            end
            neg0_s: begin
                // A <= -A when the divisor is negative
                ctrl_o.opa_inv   = 1'b1;
                ctrl_o.opb_clr_n = 1'b0;
                ctrl_o.adder_cin = 1'b1;
                ctrl_o.opa_ld    = status_i.opa_neg & status_i.signed_div_r;
                neg_ld           = 1'b1;
                state_d = (status_i.opc_neg & status_i.signed_div_r) ? neg1_s : shift_s;
            end
            neg1_s: begin
                // C <= -C
                ctrl_o.opa_clr_n = 1'b0;
                ctrl_o.opb_inv   = 1'b1;
                ctrl_o.adder_cin = 1'b1;
                ctrl_o.opc_sel   = 3'b010;
                ctrl_o.opc_ld    = 1'b1;
                state_d          = shift_s;
            end
            shift_s: begin
                ctrl_o.opb_sel   = 3'b100;
                ctrl_o.opb_ld    = 1'b1;
                ctrl_o.opc_sel   = 3'b000;
                ctrl_o.opc_ld    = 1'b1;
                ctrl_o.shift_val = full_run ? '0 : FULL_CNT - div_shift_i;
                state_d          = calc_s;
            end
            calc_s: begin
                ctrl_o.opb_sel = 3'b001;
                ctrl_o.opb_ld  = 1'b1;
                ctrl_o.opc_ld  = 1'b1;
                // first step always subtracts
                if (calc_cnt_q == '0) begin
                    ctrl_o.opa_inv   = 1'b1;
                    ctrl_o.adder_cin = 1'b1;
                end
                if (calc_done) begin
                    state_d = status_i.adder_neg ? repair_s : remain_s;
                end
            end
            repair_s: begin
                ctrl_o.opa_inv   = 1'b0;
                ctrl_o.adder_cin = 1'b0;
                ctrl_o.opb_ld    = 1'b1;
                state_d          = remain_s;
            end
            remain_s: begin
                ctrl_o.opa_clr_n = 1'b0;
                ctrl_o.opb_inv   = r_neg_q;
                ctrl_o.adder_cin = r_neg_q;
                ctrl_o.opb_ld    = 1'b1;
                state_d = (status_i.zero_divisor | ~q_neg_q) ? done_s : quot_s;
            end
            quot_s: begin
                ctrl_o.opa_clr_n = 1'b0;
                ctrl_o.opb_inv   = 1'b1;
                ctrl_o.adder_cin = 1'b1;
                ctrl_o.opc_sel   = 3'b010;
                ctrl_o.opc_ld    = 1'b1;
                state_d          = done_s;
            end
            done_s: begin
                if (yumi_i) begin
                    state_d = wait_s;
                end
            end
            default: begin
                state_d = wait_s;
            end
        endcase
    end

    assign ready_o = (state_q == wait_s);
    assign v_o     = (state_q == done_s);

    a_yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);
    a_cnt_range: assert property (
        @(posedge clk_i) disable iff (reset_i) (calc_cnt_q <= FULL_CNT) && (calc_cyc_q <= FULL_CNT)
    );

endmodule

// ==== hw/idiv_datapath.sv ====
`timescale 1ns/1ps
`include "idiv_params.svh"

module idiv_datapath (
    input  logic                   clk_i,
    input  idiv_pkg::idiv_req_t    req_i,
    input  idiv_pkg::idiv_ctrl_t   ctrl_i,
    output idiv_pkg::idiv_status_t status_o,
    output logic [`IDIV_WIDTH-1:0] opc_o,
    output idiv_pkg::idiv_resp_t   resp_o
);

    localparam int W = `IDIV_WIDTH;

    // one extra bit on every operand for the sign
    logic [W:0] opa_q;
    logic [W:0] opb_q;
    logic [W:0] opc_q;
    logic       signed_div_q;

    logic [W:0] opa_d;
    logic [W:0] opb_d;
    logic [W:0] opc_d;

    logic [W:0] divisor_ext;
    logic [W:0] dividend_ext;
    logic [W:0] b_shl;
    logic [W:0] b_opnd;
    logic [W:0] adder_a;
    logic [W:0] adder_b;
    logic [W:0] add_out;
    logic       quot_bit;

    // sign extension only for signed requests
    assign divisor_ext  = {req_i.signed_div & req_i.divisor[W-1], req_i.divisor};
    assign dividend_ext = {req_i.signed_div & req_i.dividend[W-1], req_i.dividend};

    // ====================
    // adder
    // ====================

    // partial remainder shifted left with the next dividend bit from C
    assign b_shl = {opb_q[W-1:0], opc_q[W]};

    // C goes through the adder whenever C reloads from it (negation steps)
    always_comb begin
        if (ctrl_i.opc_sel == 3'b010) begin
            b_opnd = opc_q;
        end else if (ctrl_i.opb_sel[0]) begin
            b_opnd = b_shl;
        end else begin
            b_opnd = opb_q;
        end
    end

    assign adder_a = (opa_q ^ {(W+1){ctrl_i.opa_inv}}) & {(W+1){ctrl_i.opa_clr_n}};
    assign adder_b = (b_opnd ^ {(W+1){ctrl_i.opb_inv}}) & {(W+1){ctrl_i.opb_clr_n}};
    assign add_out = adder_a + adder_b + {{W{1'b0}}, ctrl_i.adder_cin};

    // non-negative partial remainder means a one in the quotient
    assign quot_bit = ~add_out[W];

    // ====================
    // operand muxes
    // ====================

    always_comb begin
        unique case (ctrl_i.opa_sel)
            2'b10:   opa_d = divisor_ext;
            default: opa_d = add_out;
        endcase
    end

    // 100 clears B for alignment, otherwise B takes the adder result
    assign opb_d = ctrl_i.opb_sel[2] ? '0 : add_out;

    always_comb begin
        case (ctrl_i.opc_sel)
            3'b100:  opc_d = dividend_ext;
            3'b010:  opc_d = add_out;
            3'b001:  opc_d = {opc_q[W-1:0], quot_bit};
            // align the dividend so its top significant bit sits below the sign
            default: opc_d = opc_q << ctrl_i.shift_val;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.opa_ld) begin
            opa_q <= opa_d;
        end
        if (ctrl_i.opb_ld) begin
            opb_q <= opb_d;
        end
        if (ctrl_i.opc_ld) begin
            opc_q <= opc_d;
        end
        if (ctrl_i.latch_signed) begin
            signed_div_q <= req_i.signed_div;
        end
    end

    // ====================
    // flags and results
    // ====================

    assign status_o.zero_divisor = (opa_q == '0);
    assign status_o.signed_div_r = signed_div_q;
    assign status_o.adder_neg    = add_out[W];
    assign status_o.opa_neg      = opa_q[W];
    assign status_o.opc_neg      = opc_q[W];

    assign opc_o = opc_q[W-1:0];

    // quotient ends in C, remainder in B
    assign resp_o.quotient  = opc_q[W-1:0];
    assign resp_o.remainder = opb_q[W-1:0];

    // a cleared operand is only fed to the adder, never written back over itself
    a_no_ld_clr_a: assert property (@(posedge clk_i) ctrl_i.opa_ld |-> ctrl_i.opa_clr_n);
    a_no_ld_clr_b: assert property (@(posedge clk_i) ctrl_i.opb_ld |-> ctrl_i.opb_clr_n);

endmodule

// ==== hw/idiv_params.svh ====
`ifndef IDIV_PARAMS_SVH
`define IDIV_PARAMS_SVH

// operand width of the divider
`define IDIV_WIDTH 32

// holds an iteration count or a shift amount from 0 to IDIV_WIDTH
`define IDIV_CNT_W 6

`endif

// ==== hw/idiv_pkg.sv ====
`include "idiv_params.svh"

package idiv_pkg;

    typedef struct packed {
        logic [`IDIV_WIDTH-1:0] dividend;
        logic [`IDIV_WIDTH-1:0] divisor;
        logic                   signed_div;
    } idiv_req_t;

    typedef struct packed {
        logic [`IDIV_WIDTH-1:0] quotient;
        logic [`IDIV_WIDTH-1:0] remainder;
    } idiv_resp_t;

    // datapath controls, valid for the current cycle only
    typedef struct packed {
        logic [1:0]             opa_sel;
        logic                   opa_ld;
        logic                   opa_inv;
        logic                   opa_clr_n;
        logic [2:0]             opb_sel;
        logic                   opb_ld;
        logic                   opb_inv;
        logic                   opb_clr_n;
        logic [2:0]             opc_sel;
        logic                   opc_ld;
        logic                   latch_signed;
        logic                   adder_cin;
        logic [`IDIV_CNT_W-1:0] shift_val;
    } idiv_ctrl_t;

    typedef struct packed {
        logic zero_divisor;
        logic signed_div_r;
        logic adder_neg;
        logic opa_neg;
        logic opc_neg;
    } idiv_status_t;

    typedef enum logic [3:0] {
        wait_s, neg0_s, neg1_s, shift_s, calc_s, repair_s, remain_s, quot_s, done_s
    } idiv_state_e;

endpackage

// ==== hw/idiv_shift_calc.sv ====
`timescale 1ns/1ps
`include "idiv_params.svh"

module idiv_shift_calc (
    input  logic [`IDIV_WIDTH-1:0] opc_i,
    output logic [`IDIV_CNT_W-1:0] div_shift_o
);

    // ====================
    // significant bit count
    // ====================

    // the highest set bit wins, so scan upward and let later hits override
    logic [`IDIV_CNT_W-1:0] sig_bits;

    always_comb begin
        sig_bits = '0;
        for (int i = 0; i < `IDIV_WIDTH; i++) begin
            if (opc_i[i]) begin
                sig_bits = `IDIV_CNT_W'(i + 1);
            end
        end
    end

    // zero dividend gives zero, full-width dividend gives IDIV_WIDTH
    assign div_shift_o = sig_bits;

endmodule

// ==== hw/idiv_top.sv ====
`timescale 1ns/1ps
`include "idiv_params.svh"

module idiv_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 v_i,
    input  idiv_pkg::idiv_req_t  req_i,
    output logic                 ready_o,
    output logic                 v_o,
    output idiv_pkg::idiv_resp_t resp_o,
    input  logic                 yumi_i
);

    import idiv_pkg::*;

    idiv_ctrl_t             ctrl;
    idiv_status_t           status;
    logic [`IDIV_WIDTH-1:0] opc_q;
    logic [`IDIV_CNT_W-1:0] div_shift;

    idiv_controller i_ctrl (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .v_i         (v_i),
        .ready_o     (ready_o),
        .status_i    (status),
        .div_shift_i (div_shift),
        .ctrl_o      (ctrl),
        .v_o         (v_o),
        .yumi_i      (yumi_i)
    );

    idiv_datapath i_dp (
        .clk_i    (clk_i),
        .req_i    (req_i),
        .ctrl_i   (ctrl),
        .status_o (status),
        .opc_o    (opc_q),
        .resp_o   (resp_o)
    );

    idiv_shift_calc i_shift (
        .opc_i       (opc_q),
        .div_shift_o (div_shift)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module idiv_tb -o idiv_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/idiv_tb_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== sim/idiv_tb.sv ====
`timescale 1ns/1ps
`include "idiv_params.svh"

module idiv_tb;

    import idiv_pkg::*;

    localparam int W            = `IDIV_WIDTH;
    localparam int CLK_HALF     = 20;
    localparam int DRV_DLY      = 2;
    localparam int RESET_CYC    = 5;
    localparam int N_UNS        = 200;
    localparam int N_SGN        = 200;
    // upper bound on the directed requests
    localparam int N_FIXED      = 40;
    localparam int MAX_YUMI_DLY = 7;
    localparam int MAX_GAP      = 2;
    localparam int CYC_LIMIT    =
        (N_UNS + N_SGN + N_FIXED) * (W + 8 + MAX_YUMI_DLY + MAX_GAP + 2) + RESET_CYC + 100;
    localparam logic [W-1:0] MIN_NEG  = {1'b1, {(W-1){1'b0}}};
    localparam logic [W-1:0] MAG_MASK = {1'b0, {(W-1){1'b1}}};

    logic       clk_i;
    logic       reset_i;
    logic       v_i;
    idiv_req_t  req_i;
    logic       ready_o;
    logic       v_o;
    idiv_resp_t resp_o;
    logic       yumi_i;

    int errors;
    int checks;
    int n_req;
    int cycle_cnt;
    int seed_ret;

    idiv_top i_dut (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .v_i     (v_i),
        .req_i   (req_i),
        .ready_o (ready_o),
        .v_o     (v_o),
        .resp_o  (resp_o),
        .yumi_i  (yumi_i)
    );

    initial clk_i = 1'b0;
    always #CLK_HALF clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYC_LIMIT) begin
            $display("timeout: the divider stopped answering after %0d cycles", cycle_cnt);
            $display("requests: %0d, checks: %0d, errors: %0d", n_req, checks, errors + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [W-1:0] exp_v,
                             input logic [W-1:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("Error: %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    // ====================
    // reference model
    // ====================

    function automatic idiv_resp_t model_div(input logic [W-1:0] a, input logic [W-1:0] b,
                                             input logic sgn);
        idiv_resp_t   r;
        logic         neg_a;
        logic         neg_b;
        logic [W-1:0] mag_a;
        logic [W-1:0] mag_b;
        logic [W-1:0] mag_q;
        logic [W-1:0] mag_r;
        if (b == '0) begin
            r.quotient  = '1;
            r.remainder = a;
        end else if (sgn && a == MIN_NEG && b == '1) begin
            r.quotient  = a;
            r.remainder = '0;
        end else begin
            neg_a = sgn & a[W-1];
            neg_b = sgn & b[W-1];
            mag_a = neg_a ? -a : a;
            mag_b = neg_b ? -b : b;
            mag_q = mag_a / mag_b;
            mag_r = mag_a % mag_b;
            // truncation toward zero, remainder follows the dividend
            r.quotient  = (neg_a ^ neg_b) ? -mag_q : mag_q;
            r.remainder = neg_a ? -mag_r : mag_r;
        end
        return r;
    endfunction

    // random word with a random number of leading zeros
    function automatic logic [W-1:0] rand_scaled();
        logic [W-1:0] raw;
        int           sh;
        raw = $urandom;
        sh  = $urandom % W;
        return raw >> sh;
    endfunction

    // ====================
    // one request and its response
    // ====================

    task automatic run_div(input string name, input logic [W-1:0] a, input logic [W-1:0] b,
                           input logic sgn);
        idiv_resp_t exp_r;
        int         lat;
        int         dly;
        exp_r = model_div(a, b, sgn);
        dly   = $urandom % (MAX_YUMI_DLY + 1);
        lat   = 0;
        v_i              = 1'b1;
        req_i.dividend   = a;
        req_i.divisor    = b;
        req_i.signed_div = sgn;
        while (!ready_o) begin
            @(posedge clk_i);
            #DRV_DLY;
        end
        @(posedge clk_i);
        #DRV_DLY;
        n_req++;
        // garbage on the request bus must not disturb the running division
        v_i              = 1'b0;
        req_i.dividend   = $urandom;
        req_i.divisor    = $urandom;
        req_i.signed_div = $urandom % 2;
        while (!v_o) begin
            check_val({name, " ready low while busy"}, 0, ready_o);
            @(posedge clk_i);
            #DRV_DLY;
            lat++;
        end
        check_val({name, " latency bound"}, 1, lat <= W + 8);
        check_val({name, " ready low with response"}, 0, ready_o);
        check_val({name, " quotient"}, exp_r.quotient, resp_o.quotient);
        check_val({name, " remainder"}, exp_r.remainder, resp_o.remainder);
        repeat (dly) begin
            @(posedge clk_i);
            #DRV_DLY;
            check_val({name, " v held"}, 1, v_o);
            check_val({name, " ready low while held"}, 0, ready_o);
            check_val({name, " quotient held"}, exp_r.quotient, resp_o.quotient);
            check_val({name, " remainder held"}, exp_r.remainder, resp_o.remainder);
        end
        yumi_i = 1'b1;
        @(posedge clk_i);
        #DRV_DLY;
        yumi_i = 1'b0;
        check_val({name, " v low after yumi"}, 0, v_o);
        check_val({name, " ready after yumi"}, 1, ready_o);
        repeat ($urandom % (MAX_GAP + 1)) begin
            @(posedge clk_i);
            #DRV_DLY;
            check_val({name, " v low while idle"}, 0, v_o);
        end
    endtask

    initial begin
        logic [W-1:0] a_val;
        logic [W-1:0] b_val;
        seed_ret  = $urandom(32'hdbf3);
        errors    = 0;
        checks    = 0;
        n_req     = 0;
        cycle_cnt = 0;
        reset_i   = 1'b1;
        v_i       = 1'b0;
        req_i     = '0;
        yumi_i    = 1'b0;
        repeat (RESET_CYC) @(posedge clk_i);
        #DRV_DLY;
        reset_i = 1'b0;
        check_val("ready after reset", 1, ready_o);
        check_val("v after reset", 0, v_o);

        // ====================
        // directed cases
        // ====================

        run_div("unsigned div by zero", 32'h1234_5678, '0, 1'b0);
        run_div("unsigned zero by zero", '0, '0, 1'b0);
        run_div("signed div by zero pos", 32'h1234_5678, '0, 1'b1);
        run_div("signed div by zero neg", 32'hfedc_ba98, '0, 1'b1);
        run_div("signed min by minus one", MIN_NEG, '1, 1'b1);
        run_div("unsigned min by all ones", MIN_NEG, '1, 1'b0);
        run_div("unsigned zero dividend", '0, 32'd7, 1'b0);
        run_div("signed zero dividend", '0, -32'd7, 1'b1);
        run_div("unsigned divisor one", 32'hdead_beef, 32'd1, 1'b0);
        run_div("signed divisor one", 32'hdead_beef, 32'd1, 1'b1);
        run_div("signed min by one", MIN_NEG, 32'd1, 1'b1);
        run_div("unsigned equal", 32'h0000_9abc, 32'h0000_9abc, 1'b0);
        run_div("unsigned equal max", '1, '1, 1'b0);
        run_div("signed equal neg", -32'd12345, -32'd12345, 1'b1);
        run_div("unsigned divisor larger", 32'd5, 32'd7, 1'b0);
        run_div("unsigned divisor top bit", 32'h0000_1000, MIN_NEG, 1'b0);
        run_div("signed divisor larger neg", -32'd5, 32'd7, 1'b1);
        run_div("signed divisor larger pos", 32'd5, -32'd7, 1'b1);
        run_div("unsigned full width", '1, 32'd3, 1'b0);
        run_div("signed truncation neg", -32'd7, 32'd2, 1'b1);
        run_div("signed truncation mixed", 32'd7, -32'd2, 1'b1);

        // ====================
        // random cases
        // ====================

        for (int i = 0; i < N_UNS; i++) begin
            run_div("random unsigned", rand_scaled(), rand_scaled(), 1'b0);
        end

        for (int i = 0; i < N_SGN; i++) begin
            a_val = rand_scaled() & MAG_MASK;
            b_val = rand_scaled() & MAG_MASK;
            if (b_val == '0) begin
                b_val = 32'd1;
            end
            // low two bits of i walk through the four sign combinations
            if (i[0]) begin
                a_val = -a_val;
            end
            if (i[1]) begin
                b_val = -b_val;
            end
            run_div("random signed", a_val, b_val, 1'b1);
        end

        $display("requests: %0d, checks: %0d, errors: %0d", n_req, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+hw
hw/idiv_pkg.sv
hw/idiv_shift_calc.sv
hw/idiv_datapath.sv
hw/idiv_controller.sv
hw/idiv_top.sv
sim/idiv_tb.sv
